/* noc_flit_pkg.sv */
/*
 * NoC link definitions
 * Flit type encoding, flit structure, payload width
 * and the position of the VC number in a first flit
 */

`default_nettype none

package noc_flit_pkg;

  // Payload bits per flit
  localparam int data_width = 32;

  // VC number sits at the bottom of a first flit's data
  localparam int vc_field_lsb = 0;

  typedef enum logic [1:0] {
    FLIT_PAYLOAD = 2'b00,
    FLIT_HEADER  = 2'b01,
    FLIT_LAST    = 2'b10,
    FLIT_SINGLE  = 2'b11
  } flit_type_e;

  // Type field on top, data below
  typedef struct packed {
    flit_type_e              flit_type;
    logic [data_width-1:0]   data;
  } flit_t;

  // Closes a packet
  function automatic logic flit_is_last(input flit_type_e t);
    return (t == FLIT_LAST) || (t == FLIT_SINGLE);
  endfunction

  // Opens a packet and carries the VC
  function automatic logic flit_is_first(input flit_type_e t);
    return (t == FLIT_HEADER) || (t == FLIT_SINGLE);
  endfunction

endpackage

`default_nettype wire

/* dma_buffer_pkg.sv */
/*
 * Receive buffer sizing
 * FIFO depth, VC count, index and size widths
 * and the arbiter state encoding
 */

`default_nettype none

package dma_buffer_pkg;

  // Flits held per packet buffer
  localparam int fifo_depth = 16;

  // One buffer per virtual channel
  localparam int num_vc = 4;
  localparam int vc_width = 2;

  // Packet length in flits, 1 to fifo_depth
  localparam int size_width = 5;

  // Arbiter FSM
  typedef enum logic {
    ARB_IDLE = 1'b0,
    ARB_SEND = 1'b1
  } arb_state_e;

endpackage

`default_nettype wire

/* vc_dispatch.sv */
/*
 * VC dispatcher
 * Routes each incoming packet to the buffer of its VC
 */

`timescale 1ns/100ps
`default_nettype none

module vc_dispatch (
  input  logic                  clk,
  input  logic                  rst,

  input  noc_flit_pkg::flit_t   in_flit,
  input  logic                  in_valid,
  output logic                  in_ready,

  output logic                  buf_in_valid [dma_buffer_pkg::num_vc],
  input  logic                  buf_in_ready [dma_buffer_pkg::num_vc]
);

  import noc_flit_pkg::*;
  import dma_buffer_pkg::*;

  //////////////////////////////
  // Signals
  //////////////////////////////

  logic                in_first;
  logic [vc_width-1:0] vc_q;
  logic [vc_width-1:0] vc_sel;

  //////////////////////////////
  // VC selection
  //////////////////////////////

  assign in_first = flit_is_first(in_flit.flit_type);

  // First flit names its own VC, the rest follow the stored one
  assign vc_sel = in_first ? in_flit.data[vc_field_lsb +: vc_width] : vc_q;

  // Remember the VC of the open packet
  always_ff @(posedge clk) begin
    if (rst) begin
      vc_q <= '0;
    end else if (in_valid && in_ready && in_first) begin
      vc_q <= vc_sel;
    end
  end

  // Only the chosen buffer sees valid
  always_comb begin
    for (int v = 0; v < num_vc; v++) begin
      buf_in_valid[v] = in_valid && (vc_sel == vc_width'(v));
    end
  end

  // Full target buffer stalls the whole link
  assign in_ready = buf_in_ready[vc_sel];

endmodule

`default_nettype wire

/* packet_buffer.sv */
/*
 * Packet buffer
 * Shift register FIFO with one-hot fill pointer
 * Offers data only once a whole packet is stored
 * and reports the length of the oldest packet
 */

`timescale 1ns/100ps
`default_nettype none

module packet_buffer (
  input  logic                                   clk,
  input  logic                                   rst,

  input  noc_flit_pkg::flit_t                    in_flit,
  input  logic                                   in_valid,
  output logic                                   in_ready,

  output noc_flit_pkg::flit_t                    out_flit,
  output logic                                   out_valid,
  input  logic                                   out_ready,

  output logic [dma_buffer_pkg::size_width-1:0]  out_size
);

  import noc_flit_pkg::*;
  import dma_buffer_pkg::*;

  //////////////////////////////
  // Storage and pointer
  //////////////////////////////

  // Slot 0 holds the oldest flit
  flit_t                 fifo_data [fifo_depth];
  logic [fifo_depth-1:0] last_flits;

  // One-hot fill level, bit k set means k flits stored
  logic [fifo_depth:0]   wr_ptr;

  logic [fifo_depth-1:0] valid_flits;
  logic [fifo_depth-1:0] last_valid;
  logic [fifo_depth-1:0] wr_slot;
  logic                  in_is_last;
  logic                  push;
  logic                  pop;

  //////////////////////////////
  // Status
  //////////////////////////////

  assign in_is_last = flit_is_last(in_flit.flit_type);
  assign push       = in_valid && in_ready;
  assign pop        = out_valid && out_ready;

  // Slot i is filled when the level is above i
  always_comb begin
    valid_flits[fifo_depth-1] = wr_ptr[fifo_depth];
    for (int i = fifo_depth - 2; i >= 0; i--) begin
      valid_flits[i] = wr_ptr[i+1] | valid_flits[i+1];
    end
  end

  assign last_valid = last_flits & valid_flits;

  // Any stored last flit means a complete packet
  assign out_valid = |last_valid;
  assign out_flit  = fifo_data[0];
  assign in_ready  = !wr_ptr[fifo_depth];

  // Length of oldest packet, lowest last flag wins
  always_comb begin
    out_size = '0;
    for (int k = fifo_depth - 1; k >= 0; k--) begin
      if (last_valid[k]) begin
        out_size = size_width'(k + 1);
      end
    end
  end

  //////////////////////////////
  // Write and shift
  //////////////////////////////

  // Write slot drops by one when a pop shifts in the same cycle
  always_comb begin
    for (int i = 0; i < fifo_depth; i++) begin
      wr_slot[i] = push && (pop ? wr_ptr[i+1] : wr_ptr[i]);
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= (fifo_depth+1)'(1);
    end else if (push && !pop) begin
      wr_ptr <= wr_ptr << 1;
    end else if (!push && pop) begin
      wr_ptr <= wr_ptr >> 1;
    end
  end

  // Payload moves toward slot 0 on pop
  always_ff @(posedge clk) begin
    for (int i = 0; i < fifo_depth - 1; i++) begin
      if (wr_slot[i]) begin
        fifo_data[i] <= in_flit;
      end else if (pop) begin
        fifo_data[i] <= fifo_data[i+1];
      end
    end
    if (wr_slot[fifo_depth-1]) begin
      fifo_data[fifo_depth-1] <= in_flit;
    end
  end

  // Last flags follow the data, top slot clears on pop
  always_ff @(posedge clk) begin
    if (rst) begin
      last_flits <= '0;
    end else begin
      for (int i = 0; i < fifo_depth - 1; i++) begin
        if (wr_slot[i]) begin
          last_flits[i] <= in_is_last;
        end else if (pop) begin
          last_flits[i] <= last_flits[i+1];
        end
      end
      if (wr_slot[fifo_depth-1]) begin
        last_flits[fifo_depth-1] <= in_is_last;
      end else if (pop) begin
        last_flits[fifo_depth-1] <= 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

/* packet_arbiter.sv */
/*
 * Packet arbiter
 * Round-robin drain of the buffers, one whole packet per grant
 * Size of the packet in flight is held on out_size
 */

`timescale 1ns/100ps
`default_nettype none

module packet_arbiter (
  input  logic                                   clk,
  input  logic                                   rst,

  input  noc_flit_pkg::flit_t                    buf_out_flit  [dma_buffer_pkg::num_vc],
  input  logic                                   buf_out_valid [dma_buffer_pkg::num_vc],
  input  logic [dma_buffer_pkg::size_width-1:0]  buf_size      [dma_buffer_pkg::num_vc],
  output logic                                   buf_out_ready [dma_buffer_pkg::num_vc],

  output noc_flit_pkg::flit_t                    out_flit,
  output logic                                   out_valid,
  input  logic                                   out_ready,
  output logic [dma_buffer_pkg::size_width-1:0]  out_size
);

  import noc_flit_pkg::*;
  import dma_buffer_pkg::*;

  //////////////////////////////
  // State
  //////////////////////////////

  arb_state_e            state;
  logic [vc_width-1:0]   grant;
  logic [vc_width-1:0]   last_grant;
  logic [size_width-1:0] size_q;

  logic [vc_width-1:0]   cand;
  logic [vc_width-1:0]   pick;
  logic                  pick_valid;
  logic                  send_done;

  //////////////////////////////
  // Round-robin pick
  //////////////////////////////

  // Smallest offset past last grant wins, index wraps mod num_vc
  always_comb begin
    pick       = last_grant;
    pick_valid = 1'b0;
    cand       = last_grant;
    for (int o = num_vc; o >= 1; o--) begin
      cand = last_grant + vc_width'(o);
      if (buf_out_valid[cand]) begin
        pick       = cand;
        pick_valid = 1'b1;
      end
    end
  end

  // Last flit of the granted packet leaves
  assign send_done = out_valid && out_ready && flit_is_last(out_flit.flit_type);

  always_ff @(posedge clk) begin
    if (rst) begin
      state      <= ARB_IDLE;
      grant      <= '0;
      last_grant <= vc_width'(num_vc - 1);
    end else begin
      case (state)
        ARB_IDLE: if (pick_valid) begin
          state <= ARB_SEND;
          grant <= pick;
        end
        ARB_SEND: if (send_done) begin
          state      <= ARB_IDLE;
          last_grant <= grant;
        end
        default: state <= ARB_IDLE;
      endcase
    end
  end

  // Size captured together with the grant
  always_ff @(posedge clk) begin
    if (state == ARB_IDLE && pick_valid) begin
      size_q <= buf_size[pick];
    end
  end

  //////////////////////////////
  // Output path
  //////////////////////////////

  // Granted buffer passes straight through
  assign out_flit  = buf_out_flit[grant];
  assign out_valid = (state == ARB_SEND) && buf_out_valid[grant];
  assign out_size  = size_q;

  always_comb begin
    for (int v = 0; v < num_vc; v++) begin
      buf_out_ready[v] = (state == ARB_SEND) && (grant == vc_width'(v)) && out_ready;
    end
  end

endmodule

`default_nettype wire

/* packet_rx_subsystem.sv */
/*
 * Receive subsystem top
 * Dispatcher, per-VC packet buffers and output arbiter
 */

`timescale 1ns/100ps
`default_nettype none

module packet_rx_subsystem (
  input  logic                                   clk,
  input  logic                                   rst,

  input  noc_flit_pkg::flit_t                    in_flit,
  input  logic                                   in_valid,
  output logic                                   in_ready,

  output noc_flit_pkg::flit_t                    out_flit,
  output logic                                   out_valid,
  input  logic                                   out_ready,
  output logic [dma_buffer_pkg::size_width-1:0]  out_size
);

  import noc_flit_pkg::*;
  import dma_buffer_pkg::*;

  //////////////////////////////
  // Per-VC buses
  //////////////////////////////

  logic                  buf_in_valid  [num_vc];
  logic                  buf_in_ready  [num_vc];
  flit_t                 buf_out_flit  [num_vc];
  logic                  buf_out_valid [num_vc];
  logic                  buf_out_ready [num_vc];
  logic [size_width-1:0] buf_size      [num_vc];

  // Input steering
  vc_dispatch u_vc_dispatch (
    .clk          (clk),
    .rst          (rst),
    .in_flit      (in_flit),
    .in_valid     (in_valid),
    .in_ready     (in_ready),
    .buf_in_valid (buf_in_valid),
    .buf_in_ready (buf_in_ready)
  );

  // Flit fans out to every buffer, valid picks one
  for (genvar v = 0; v < num_vc; v++) begin : g_buf
    packet_buffer u_packet_buffer (
      .clk       (clk),
      .rst       (rst),
      .in_flit   (in_flit),
      .in_valid  (buf_in_valid[v]),
      .in_ready  (buf_in_ready[v]),
      .out_flit  (buf_out_flit[v]),
      .out_valid (buf_out_valid[v]),
      .out_ready (buf_out_ready[v]),
      .out_size  (buf_size[v])
    );
  end

  // Output drain
  packet_arbiter u_packet_arbiter (
    .clk           (clk),
    .rst           (rst),
    .buf_out_flit  (buf_out_flit),
    .buf_out_valid (buf_out_valid),
    .buf_size      (buf_size),
    .buf_out_ready (buf_out_ready),
    .out_flit      (out_flit),
    .out_valid     (out_valid),
    .out_ready     (out_ready),
    .out_size      (out_size)
  );

endmodule

`default_nettype wire

/* tb_packet_rx_subsystem.sv */
/*
 * Testbench for the packet receive subsystem
 * Clock, reset, random packet stimulus on random VCs,
 * per-VC reference queues, assertions and closing report
 */

`timescale 1ns/100ps
`default_nettype none

module tb_packet_rx_subsystem;

  import noc_flit_pkg::*;
  import dma_buffer_pkg::*;

  localparam int num_pkts     = 60;
  localparam int stall_cycles = 200;
  localparam int pat_len      = 8192;
  // VC that gets the stalled partial packet
  localparam int stall_vc     = 2;

  logic                  clk;
  logic                  rst;
  flit_t                 in_flit;
  logic                  in_valid;
  logic                  in_ready;
  flit_t                 out_flit;
  logic                  out_valid;
  logic                  out_ready;
  logic [size_width-1:0] out_size;

  int seed;
  int errors;
  int packets;
  int tests;
  int cycle;
  int limit;
  bit ready_pat [pat_len];
  logic [vc_width-1:0] pkt_vc [num_pkts];
  int pkt_len [num_pkts];

  // Reference model, expected flits and sizes per VC
  flit_t flit_q [num_vc][$];
  int    size_q [num_vc][$];
  logic [vc_width-1:0] in_vc;
  int    in_len;
  logic [vc_width-1:0] out_vc;
  int    out_cnt;
  int    cur_size;
  logic  out_busy;

  packet_rx_subsystem u_packet_rx_subsystem (
    .clk       (clk),
    .rst       (rst),
    .in_flit   (in_flit),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .out_flit  (out_flit),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_size  (out_size)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  //////////////////////////////
  // Helpers
  //////////////////////////////

  // Header or single flit
  function automatic logic opens_packet(input flit_type_e t);
    return (t == FLIT_HEADER) || (t == FLIT_SINGLE);
  endfunction

  // Last or single flit
  function automatic logic closes_packet(input flit_type_e t);
    return (t == FLIT_LAST) || (t == FLIT_SINGLE);
  endfunction

  function automatic logic queues_empty();
    for (int v = 0; v < num_vc; v++) begin
      if (flit_q[v].size() != 0 || size_q[v].size() != 0) begin
        return 1'b0;
      end
    end
    return !out_busy;
  endfunction

  // Present one flit, hold it until the DUT takes it
  task automatic send_flit(input flit_type_e t, input logic [data_width-1:0] d);
    @(negedge clk);
    in_flit.flit_type = t;
    in_flit.data      = d;
    in_valid          = 1'b1;
    @(posedge clk);
    while (!in_ready) begin
      @(posedge clk);
    end
  endtask

  // Flits first to first+count-1 of a packet of length len
  task automatic send_part(input int vc, input int len, input int first, input int count);
    logic [data_width-1:0] d;
    flit_type_e            t;
    for (int i = first; i < first + count; i++) begin
      d = $random(seed);
      if (i == 0) begin
        d[vc_field_lsb +: vc_width] = vc_width'(vc);
      end
      if (len == 1) t = FLIT_SINGLE;
      else if (i == 0) t = FLIT_HEADER;
      else if (i == len - 1) t = FLIT_LAST;
      else t = FLIT_PAYLOAD;
      send_flit(t, d);
    end
  endtask

  task automatic go_idle();
    @(negedge clk);
    in_valid = 1'b0;
  endtask

  task automatic wait_drain();
    while (!queues_empty()) begin
      @(negedge clk);
    end
  endtask

  task automatic report_test(input string name, input int base);
    tests++;
    $display("test %s: %0d errors", name, errors - base);
  endtask

  //////////////////////////////
  // Monitors and assertions
  //////////////////////////////

  // Accepted input flits feed the reference queues
  always @(posedge clk) begin
    if (!rst && in_valid && in_ready) begin
      if (opens_packet(in_flit.flit_type)) begin
        in_vc  = in_flit.data[vc_field_lsb +: vc_width];
        in_len = 0;
      end
      flit_q[in_vc].push_back(in_flit);
      in_len++;
      // Packet becomes visible to the checker only when complete
      if (closes_packet(in_flit.flit_type)) begin
        size_q[in_vc].push_back(in_len);
      end
    end
  end

  // Output flits against the oldest packet of their VC
  always @(posedge clk) begin
    flit_t expected;
    if (!rst && out_valid && out_ready) begin
      if (!out_busy) begin
        out_vc = out_flit.data[vc_field_lsb +: vc_width];
        assert (opens_packet(out_flit.flit_type)) else begin
          errors++;
          $display("output packet does not begin with a first flit");
        end
        assert (size_q[out_vc].size() > 0) else begin
          errors++;
          $display("output on VC %0d, which holds no complete packet", out_vc);
        end
        cur_size = (size_q[out_vc].size() > 0) ? size_q[out_vc].pop_front() : 0;
        out_busy = 1'b1;
        out_cnt  = 0;
        packets++;
      end else begin
        assert (!opens_packet(out_flit.flit_type)) else begin
          errors++;
          $display("first flit inside an open output packet, packets interleaved");
        end
      end
      assert (out_size == size_width'(cur_size)) else begin
        errors++;
        $display("ERR out_size expected %h got %h", cur_size, out_size);
      end
      expected = (flit_q[out_vc].size() > 0) ? flit_q[out_vc].pop_front() : '0;
      assert (out_flit == expected) else begin
        errors++;
        $display("ERR out_flit expected %h got %h", expected, out_flit);
      end
      out_cnt++;
      if (closes_packet(out_flit.flit_type)) begin
        out_busy = 1'b0;
        assert (out_cnt == cur_size) else begin
          errors++;
          $display("packet on VC %0d ended after %0d flits, expected %0d",
                   out_vc, out_cnt, cur_size);
        end
      end
    end
  end

  // State right after reset
  assert property (@(posedge clk) $fell(rst) |-> (!out_valid && in_ready)) else begin
    errors++;
    $display("ERR out_valid %h in_ready %h after reset",
             $sampled(out_valid), $sampled(in_ready));
  end

  // Back-pressure holds the offered flit and size
  assert property (@(posedge clk) disable iff (rst)
                   (out_valid && !out_ready) |=> (out_valid && $stable(out_flit))) else begin
    errors++;
    $display("ERR out_flit held %h now %h valid %h",
             $past(out_flit), $sampled(out_flit), $sampled(out_valid));
  end

  assert property (@(posedge clk) disable iff (rst)
                   (out_valid && !out_ready) |=> $stable(out_size)) else begin
    errors++;
    $display("ERR out_size held %h now %h", $past(out_size), $sampled(out_size));
  end

  //////////////////////////////
  // Ready pattern and watchdog
  //////////////////////////////

  // Pattern indexed by rising edges seen so far
  always @(negedge clk) begin
    out_ready = ready_pat[cycle % pat_len];
  end

  always @(posedge clk) begin
    cycle++;
    if (limit > 0 && cycle > limit) begin
      $display("timeout after %0d cycles, output never drained", cycle);
      $display("Done: errors found");
      $finish;
    end
  end

  //////////////////////////////
  // Stimulus
  //////////////////////////////

  initial begin
    int base;
    int total;
    seed      = 32'h75df;
    errors    = 0;
    packets   = 0;
    tests     = 0;
    cycle     = 0;
    limit     = 0;
    out_busy  = 1'b0;
    in_vc     = '0;
    in_len    = 0;
    rst       = 1'b1;
    in_valid  = 1'b0;
    in_flit   = '0;
    out_ready = 1'b0;
    // Ready high about three cycles in four
    for (int i = 0; i < pat_len; i++) begin
      ready_pat[i] = ($random(seed) & 3) != 0;
    end
    total = 7;
    for (int p = 0; p < num_pkts; p++) begin
      pkt_vc[p]  = vc_width'($random(seed));
      pkt_len[p] = ($unsigned($random(seed)) % fifo_depth) + 1;
      total += pkt_len[p];
    end
    limit = total * 4 + 200 + stall_cycles;
    repeat (16) @(negedge clk);
    rst  = 1'b0;
    base = errors;
    repeat (2) @(negedge clk);
    report_test("reset", base);

    // Random packets on random VCs
    base = errors;
    for (int p = 0; p < 30; p++) begin
      send_part(pkt_vc[p], pkt_len[p], 0, pkt_len[p]);
    end
    go_idle();
    wait_drain();
    report_test("random traffic", base);

    // Complete packets, then a partial one left hanging
    base = errors;
    for (int p = 30; p < 40; p++) begin
      send_part(pkt_vc[p], pkt_len[p], 0, pkt_len[p]);
    end
    send_part(stall_vc, 7, 0, 4);
    go_idle();
    repeat (stall_cycles) @(negedge clk);
    for (int v = 0; v < num_vc; v++) begin
      assert (size_q[v].size() == 0 && flit_q[v].size() == ((v == stall_vc) ? 4 : 0)) else begin
        errors++;
        $display("VC %0d not drained as expected during stall, %0d flits left",
                 v, flit_q[v].size());
      end
    end
    send_part(stall_vc, 7, 4, 3);
    go_idle();
    wait_drain();
    report_test("stalled packet", base);

    // Back-to-back packets under random back-pressure
    base = errors;
    for (int p = 40; p < num_pkts; p++) begin
      send_part(pkt_vc[p], pkt_len[p], 0, pkt_len[p]);
    end
    go_idle();
    wait_drain();
    report_test("back-pressure", base);

    $display("tests %0d, packets %0d, errors %0d", tests, packets, errors);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* src.f */
noc_flit_pkg.sv
dma_buffer_pkg.sv
vc_dispatch.sv
packet_buffer.sv
packet_arbiter.sv
packet_rx_subsystem.sv
tb_packet_rx_subsystem.sv
